/* run_sim.sh */
#!/bin/sh
# Build the cJTAG bridge testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_cjtag_bridge \
    -f src.f \
    -o sim_cjtag

./obj_dir/sim_cjtag > sim.log 2>&1
cat sim.log

# The testbench prints the fail message on any error or timeout
if grep -q "TEST FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

/* sim/cjtag_stimulus.txt */
# Columns: ESC toggles online | OAC bit0 bit1 bit2 bit3 online | PKT ntdi tms tdo
# Code bits are sent LSB first and online is the level expected after the last fall
# Escapes that must not wake the bridge
ESC 4 0
ESC 5 0
ESC 8 0
# Selection followed by a wrong code
ESC 6 0
OAC 1 0 0 1 0
# Selection followed by the correct code
ESC 7 0
OAC 1 1 0 1 1
PKT 1 1 0
PKT 0 0 1
PKT 1 0 1
PKT 0 1 0
# Deselection and a new activation
ESC 4 0
ESC 6 0
OAC 1 1 0 1 1
PKT 0 1 1
PKT 1 1 1
# Reset escape and a last activation
ESC 9 0
ESC 7 0
OAC 1 1 0 1 1
PKT 1 0 0
ESC 5 0

/* sim/tb_cjtag_bridge.sv */
/* Testbench for the cJTAG to JTAG bridge
   Replays probe records from a stimulus file and checks the JTAG side */

`timescale 1ns/100ps

module tb_cjtag_bridge;

    // Clocks per TCKC phase, phases per record for the timeout, settle time
    localparam int PHASE_CLKS  = 5;
    localparam int REC_PHASES  = 30;
    localparam int SETTLE_CLKS = 10;

    logic clk_i = 1'b0;
    logic ntrst_i;
    logic tckc_i;
    logic tmsc_i;
    logic tdo_i;
    logic tmsc_o;
    logic tmsc_oen_o;
    logic tck_o;
    logic tms_o;
    logic tdi_o;
    logic online_o;

    // Records from the stimulus file, f4 holds the expected online level
    logic [23:0] rec_op [$];
    int          rec_f0 [$];
    int          rec_f1 [$];
    int          rec_f2 [$];
    int          rec_f3 [$];
    int          rec_f4 [$];

    int check_cnt   = 0;
    int error_cnt   = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 200;
    int seed        = 32'h2649;

    // TCK edge monitor state
    logic tck_prev     = 1'b0;
    int   tck_rises    = 0;
    logic tdi_at_rise  = 1'b0;
    logic tms_at_rise  = 1'b0;
    logic tck_hold_bad = 1'b0;

    cjtag_bridge cjtag_bridge_inst (
        .clk_i      (clk_i),
        .ntrst_i    (ntrst_i),
        .tckc_i     (tckc_i),
        .tmsc_i     (tmsc_i),
        .tmsc_o     (tmsc_o),
        .tmsc_oen_o (tmsc_oen_o),
        .tck_o      (tck_o),
        .tms_o      (tms_o),
        .tdi_o      (tdi_o),
        .tdo_i      (tdo_i),
        .online_o   (online_o)
    );

    // 10 ns system clock
    initial begin
        forever #5 clk_i = ~clk_i;
    end

    // ====================
    // Watchdog and monitor
    // ====================
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Run timed out after %0d clock cycles", cycle_cnt);
            $display("Checks: %0d, errors: %0d", check_cnt, error_cnt + 1);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Sampled mid-cycle, DUT outputs move on the rising edge
    always @(negedge clk_i) begin
        if (tck_o && !tck_prev) begin
            tck_rises   = tck_rises + 1;
            tdi_at_rise = tdi_o;
            tms_at_rise = tms_o;
        end else if (tck_o && (tdi_o != tdi_at_rise || tms_o != tms_at_rise)) begin
            tck_hold_bad = 1'b1;
        end
        tck_prev = tck_o;
    end

    // ====================
    // Helpers
    // ====================
    task automatic check_val(input logic expected, input logic actual, input string what);
        check_cnt = check_cnt + 1;
        if (expected !== actual) begin
            error_cnt = error_cnt + 1;
            $display("Fail at %0t ns: %s expected %b got %b", $time, what, expected, actual);
        end
    endtask

    task automatic wait_clks(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    function automatic logic random_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    // Sets the bit in the low phase and returns just before the fall
    task automatic drive_bit_high(input logic bit_val, input logic tdo_val);
        wait_clks(2);
        tmsc_i = bit_val;
        tdo_i  = tdo_val;
        wait_clks(PHASE_CLKS - 2);
        tckc_i = 1'b1;
        wait_clks(PHASE_CLKS);
    endtask

    // TCKC held high while TMSC toggles every 2 clocks
    task automatic drive_escape(input int toggles);
        wait_clks(PHASE_CLKS);
        tckc_i = 1'b1;
        repeat (toggles) begin
            wait_clks(2);
            tmsc_i = !tmsc_i;
        end
        wait_clks(3);
        tckc_i = 1'b0;
    endtask

    task automatic check_idle();
        check_val(1'b0, tck_o, "tck_o idle");
        check_val(1'b1, tms_o, "tms_o idle");
        check_val(1'b0, tdi_o, "tdi_o idle");
        check_val(1'b1, tmsc_oen_o, "tmsc_oen_o idle");
    endtask

    task automatic run_escape(input int toggles, input logic exp_online);
        drive_escape(toggles);
        wait_clks(SETTLE_CLKS);
        check_val(exp_online, online_o, "online_o after escape");
        if (!exp_online) begin
            check_idle();
        end
    endtask

    task automatic run_oac(input logic b0, input logic b1, input logic b2, input logic b3,
                           input logic exp_online);
        drive_bit_high(b0, random_bit());
        tckc_i = 1'b0;
        drive_bit_high(b1, random_bit());
        tckc_i = 1'b0;
        drive_bit_high(b2, random_bit());
        tckc_i = 1'b0;
        drive_bit_high(b3, random_bit());
        tckc_i = 1'b0;
        wait_clks(SETTLE_CLKS);
        check_val(exp_online, online_o, "online_o after code");
        if (!exp_online) begin
            check_idle();
        end
    endtask

    task automatic run_packet(input logic ntdi, input logic tms, input logic tdo);
        int rises_before;
        rises_before = tck_rises;
        check_val(1'b1, online_o, "online_o at packet start");
        drive_bit_high(ntdi, random_bit());
        check_val(1'b1, tmsc_oen_o, "probe owns TMSC in nTDI bit");
        tckc_i = 1'b0;
        drive_bit_high(tms, random_bit());
        check_val(1'b1, tmsc_oen_o, "probe owns TMSC in TMS bit");
        tckc_i = 1'b0;
        // Probe keeps its level while the bridge returns TDO
        drive_bit_high(tmsc_i, tdo);
        check_val(1'b0, tmsc_oen_o, "bridge drives TMSC in TDO bit");
        check_val(tdo, tmsc_o, "returned TDO on tmsc_o");
        tckc_i = 1'b0;
        wait_clks(SETTLE_CLKS);
        check_val(1'b0, tck_o, "tck_o low after packet");
        check_val(1'b1, tck_rises == rises_before + 1, "one TCK rise per packet");
        check_val(!ntdi, tdi_at_rise, "tdi_o at TCK rise");
        check_val(tms, tms_at_rise, "tms_o at TCK rise");
        check_val(1'b0, tck_hold_bad, "tdi_o and tms_o stable while TCK high");
    endtask

    // Lines starting with a lone # token are skipped
    task automatic load_records(input int fd);
        logic [23:0]      op;
        logic [8*160-1:0] rest;
        int               n;
        int               f0;
        int               f1;
        int               f2;
        int               f3;
        int               f4;
        logic             done;
        done = 1'b0;
        while (!done) begin
            op = '0;
            f0 = 0;
            f1 = 0;
            f2 = 0;
            f3 = 0;
            f4 = 0;
            n  = $fscanf(fd, "%s", op);
            if (n != 1) begin
                done = 1'b1;
            end else if (op == {16'h0000, "#"}) begin
                n = $fgets(rest, fd);
            end else begin
                case (op)
                    "ESC":   n = $fscanf(fd, "%d %d", f0, f4) - 2;
                    "OAC":   n = $fscanf(fd, "%d %d %d %d %d", f0, f1, f2, f3, f4) - 5;
                    "PKT":   n = $fscanf(fd, "%d %d %d", f0, f1, f2) - 3;
                    default: n = -1;
                endcase
                if (n != 0) begin
                    $display("Stimulus record %0d is malformed or has an unknown opcode",
                             rec_op.size() + 1);
                    error_cnt = error_cnt + 1;
                    done      = 1'b1;
                end else begin
                    rec_op.push_back(op);
                    rec_f0.push_back(f0);
                    rec_f1.push_back(f1);
                    rec_f2.push_back(f2);
                    rec_f3.push_back(f3);
                    rec_f4.push_back(f4);
                end
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        int fd;
        ntrst_i = 1'b0;
        tckc_i  = 1'b0;
        tmsc_i  = 1'b0;
        tdo_i   = 1'b0;
        fd = $fopen("sim/cjtag_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/cjtag_stimulus.txt");
            error_cnt = error_cnt + 1;
        end else begin
            load_records(fd);
            $fclose(fd);
        end
        cycle_limit = rec_op.size() * REC_PHASES * PHASE_CLKS + 200;

        wait_clks(16);
        ntrst_i = 1'b1;
        wait_clks(2);
        check_val(1'b0, online_o, "online_o after reset");
        check_val(1'b0, tmsc_o, "tmsc_o after reset");
        check_idle();

        for (int i = 0; i < rec_op.size(); i++) begin
            case (rec_op[i])
                "ESC":   run_escape(rec_f0[i], rec_f4[i] != 0);
                "OAC":   run_oac(rec_f0[i] != 0, rec_f1[i] != 0, rec_f2[i] != 0,
                                 rec_f3[i] != 0, rec_f4[i] != 0);
                default: run_packet(rec_f0[i] != 0, rec_f1[i] != 0, rec_f2[i] != 0);
            endcase
        end

        wait_clks(SETTLE_CLKS);
        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* source/cjtag_bridge.sv */
/* cJTAG to JTAG bridge top level
   Turns the two-pin TCKC/TMSC probe link into a four-pin JTAG TAP port */

`timescale 1ns/100ps

module cjtag_bridge (
    input  logic clk_i,
    input  logic ntrst_i,
    // Probe side
    input  logic tckc_i,
    input  logic tmsc_i,
    output logic tmsc_o,
    output logic tmsc_oen_o,
    // TAP side
    output logic tck_o,
    output logic tms_o,
    output logic tdi_o,
    input  logic tdo_i,
    // High while in OScan1
    output logic online_o
);

    // ====================
    // Internal signals
    // ====================
    logic                     tckc_s;
    logic                     tmsc_s;
    logic                     tckc_rise;
    logic                     tckc_fall;
    logic                     tmsc_toggle;
    cjtag_pkg::esc_kind_t     esc_kind;
    cjtag_pkg::bridge_state_t state;
    cjtag_pkg::pkt_pos_t      pkt_pos;
    logic                     tmsc_bit;

    // Probe pins into the clock domain
    cjtag_input_sync input_sync_inst (
        .clk_i         (clk_i),
        .ntrst_i       (ntrst_i),
        .tckc_i        (tckc_i),
        .tmsc_i        (tmsc_i),
        .tckc_s_o      (tckc_s),
        .tmsc_s_o      (tmsc_s),
        .tckc_rise_o   (tckc_rise),
        .tckc_fall_o   (tckc_fall),
        .tmsc_toggle_o (tmsc_toggle)
    );

    // Escape classification per high phase
    cjtag_escape_detector escape_detector_inst (
        .clk_i         (clk_i),
        .ntrst_i       (ntrst_i),
        .tckc_s_i      (tckc_s),
        .tckc_rise_i   (tckc_rise),
        .tckc_fall_i   (tckc_fall),
        .tmsc_toggle_i (tmsc_toggle),
        .esc_kind_o    (esc_kind)
    );

    // Protocol state and packet slot
    cjtag_ctrl_fsm ctrl_fsm_inst (
        .clk_i       (clk_i),
        .ntrst_i     (ntrst_i),
        .tckc_fall_i (tckc_fall),
        .tmsc_s_i    (tmsc_s),
        .esc_kind_i  (esc_kind),
        .state_o     (state),
        .pkt_pos_o   (pkt_pos),
        .tmsc_bit_o  (tmsc_bit)
    );

    // JTAG pin generation
    oscan1_jtag_driver jtag_driver_inst (
        .clk_i       (clk_i),
        .ntrst_i     (ntrst_i),
        .tckc_rise_i (tckc_rise),
        .tckc_fall_i (tckc_fall),
        .tdo_i       (tdo_i),
        .tmsc_bit_i  (tmsc_bit),
        .state_i     (state),
        .pkt_pos_i   (pkt_pos),
        .tck_o       (tck_o),
        .tms_o       (tms_o),
        .tdi_o       (tdi_o),
        .tmsc_o      (tmsc_o),
        .tmsc_oen_o  (tmsc_oen_o)
    );

    assign online_o = state == cjtag_pkg::st_oscan1;

endmodule

/* source/cjtag_ctrl_fsm.sv */
/* cJTAG control FSM
   Handles escapes, activation code check and OScan1 packet position */

`timescale 1ns/100ps

module cjtag_ctrl_fsm (
    input  logic                     clk_i,
    input  logic                     ntrst_i,
    input  logic                     tckc_fall_i,
    input  logic                     tmsc_s_i,
    input  cjtag_pkg::esc_kind_t     esc_kind_i,
    output cjtag_pkg::bridge_state_t state_o,
    output cjtag_pkg::pkt_pos_t      pkt_pos_o,
    output logic                     tmsc_bit_o
);

    // Earlier code bits, newest at the top
    logic [cjtag_pkg::OAC_BITS-2:0]         oac_shift;
    // Number of code bits already received
    logic [$clog2(cjtag_pkg::OAC_BITS)-1:0] oac_cnt;
    // Full code once the current bit is added
    logic [cjtag_pkg::OAC_BITS-1:0]         oac_rx;

    // LSB first, so the newest bit lands in the MSB
    assign oac_rx = {tmsc_s_i, oac_shift};

    // ====================
    // State machine
    // ====================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            state_o    <= cjtag_pkg::st_offline;
            pkt_pos_o  <= cjtag_pkg::pos_ntdi;
            tmsc_bit_o <= 1'b0;
            oac_shift  <= '0;
            oac_cnt    <= '0;
        end else if (tckc_fall_i) begin
            // Everything advances on a TCKC fall only
            case (state_o)
                cjtag_pkg::st_offline: begin
                    // Only a selection escape wakes the bridge
                    if (esc_kind_i == cjtag_pkg::esc_select) begin
                        state_o   <= cjtag_pkg::st_online_act;
                        oac_shift <= '0;
                        oac_cnt   <= '0;
                    end
                end

                cjtag_pkg::st_online_act: begin
                    if (esc_kind_i == cjtag_pkg::esc_reset) begin
                        // Reset escape wins over code reception
                        state_o <= cjtag_pkg::st_offline;
                        oac_cnt <= '0;
                    end else if (oac_cnt == (cjtag_pkg::OAC_BITS - 1)) begin
                        // Last code bit, check the whole word
                        oac_cnt <= '0;
                        if (oac_rx == cjtag_pkg::OAC_VALUE) begin
                            state_o   <= cjtag_pkg::st_oscan1;
                            pkt_pos_o <= cjtag_pkg::pos_ntdi;
                        end else begin
                            state_o <= cjtag_pkg::st_offline;
                        end
                    end else begin
                        oac_shift <= oac_rx[cjtag_pkg::OAC_BITS-1:1];
                        oac_cnt   <= oac_cnt + 1'b1;
                    end
                end

                cjtag_pkg::st_oscan1: begin
                    if (esc_kind_i == cjtag_pkg::esc_deselect ||
                        esc_kind_i == cjtag_pkg::esc_reset) begin
                        // Drop out and restart packets from the first slot
                        state_o   <= cjtag_pkg::st_offline;
                        pkt_pos_o <= cjtag_pkg::pos_ntdi;
                    end else begin
                        tmsc_bit_o <= tmsc_s_i;
                        // Step nTDI, TMS, TDO and wrap
                        case (pkt_pos_o)
                            cjtag_pkg::pos_ntdi: pkt_pos_o <= cjtag_pkg::pos_tms;
                            cjtag_pkg::pos_tms:  pkt_pos_o <= cjtag_pkg::pos_tdo;
                            default:             pkt_pos_o <= cjtag_pkg::pos_ntdi;
                        endcase
                    end
                end

                default: begin
                    // Unused encoding, recover to offline
                    state_o   <= cjtag_pkg::st_offline;
                    pkt_pos_o <= cjtag_pkg::pos_ntdi;
                end
            endcase
        end
    end

endmodule

/* source/cjtag_escape_detector.sv */
/* cJTAG escape detector
   Counts TMSC toggles per TCKC high phase and classifies the escape */

`timescale 1ns/100ps

module cjtag_escape_detector (
    input  logic                 clk_i,
    input  logic                 ntrst_i,
    input  logic                 tckc_s_i,
    input  logic                 tckc_rise_i,
    input  logic                 tckc_fall_i,
    input  logic                 tmsc_toggle_i,
    output cjtag_pkg::esc_kind_t esc_kind_o
);

    // Set between a TCKC rise and the following fall
    logic                                tckc_high;
    // Toggles in the current or latest high phase
    logic [cjtag_pkg::TOGGLE_CNT_W-1:0]  toggle_cnt;

    // ====================
    // Toggle counter
    // ====================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            tckc_high  <= 1'b0;
            toggle_cnt <= '0;
        end else begin
            if (tckc_rise_i) begin
                // New high phase starts a fresh count
                tckc_high  <= 1'b1;
                toggle_cnt <= '0;
            end else if (tckc_fall_i) begin
                // Count is kept so the FSM can read it at the fall
                tckc_high <= 1'b0;
            end else if (tckc_high && tckc_s_i && tmsc_toggle_i) begin
                // Saturate instead of wrapping on long escapes
                if (toggle_cnt != '1) begin
                    toggle_cnt <= toggle_cnt + 1'b1;
                end
            end
        end
    end

    // ====================
    // Classification
    // ====================
    // Combinational so it is valid in the tckc_fall cycle
    always_comb begin
        esc_kind_o = cjtag_pkg::esc_none;
        if (toggle_cnt >= cjtag_pkg::ESC_RESET_MIN) begin
            esc_kind_o = cjtag_pkg::esc_reset;
        end else if (toggle_cnt >= cjtag_pkg::ESC_SEL_MIN &&
                     toggle_cnt <= cjtag_pkg::ESC_SEL_MAX) begin
            esc_kind_o = cjtag_pkg::esc_select;
        end else if (toggle_cnt >= cjtag_pkg::ESC_DESEL_MIN &&
                     toggle_cnt <= cjtag_pkg::ESC_DESEL_MAX) begin
            esc_kind_o = cjtag_pkg::esc_deselect;
        end
        // 0 to 3 toggles stay esc_none
    end

endmodule

/* source/cjtag_input_sync.sv */
/* cJTAG probe input synchronizer
   Brings TCKC and TMSC into the system clock domain and flags their edges */

`timescale 1ns/100ps

module cjtag_input_sync (
    input  logic clk_i,
    input  logic ntrst_i,
    input  logic tckc_i,
    input  logic tmsc_i,
    output logic tckc_s_o,
    output logic tmsc_s_o,
    output logic tckc_rise_o,
    output logic tckc_fall_o,
    output logic tmsc_toggle_o
);

    // Flop chains, index 0 samples the pin
    logic [cjtag_pkg::SYNC_STAGES-1:0] tckc_sync;
    logic [cjtag_pkg::SYNC_STAGES-1:0] tmsc_sync;
    // Synchronized levels from the previous cycle
    logic                              tckc_prev;
    logic                              tmsc_prev;

    // ====================
    // Synchronizers
    // ====================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            tckc_sync <= '0;
            tmsc_sync <= '0;
        end else begin
            tckc_sync <= {tckc_sync[cjtag_pkg::SYNC_STAGES-2:0], tckc_i};
            tmsc_sync <= {tmsc_sync[cjtag_pkg::SYNC_STAGES-2:0], tmsc_i};
        end
    end

    // Last stage is the clean level
    assign tckc_s_o = tckc_sync[cjtag_pkg::SYNC_STAGES-1];
    assign tmsc_s_o = tmsc_sync[cjtag_pkg::SYNC_STAGES-1];

    // ====================
    // Edge pulses
    // ====================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            tckc_prev     <= 1'b0;
            tmsc_prev     <= 1'b0;
            tckc_rise_o   <= 1'b0;
            tckc_fall_o   <= 1'b0;
            tmsc_toggle_o <= 1'b0;
        end else begin
            tckc_prev     <= tckc_s_o;
            tmsc_prev     <= tmsc_s_o;
            // One-cycle pulses, three clocks after the pin moved
            tckc_rise_o   <= !tckc_prev && tckc_s_o;
            tckc_fall_o   <= tckc_prev && !tckc_s_o;
            tmsc_toggle_o <= tmsc_prev != tmsc_s_o;
        end
    end

endmodule

/* source/cjtag_pkg.sv */
/* cJTAG bridge shared definitions
   States, escape classes, packet positions and protocol constants */

package cjtag_pkg;

    // ====================
    // Protocol constants
    // ====================

    // Toggle counter width, saturates at 31
    localparam int unsigned TOGGLE_CNT_W = 5;

    // Escape thresholds in TMSC toggles while TCKC is high
    localparam int unsigned ESC_DESEL_MIN = 4;
    localparam int unsigned ESC_DESEL_MAX = 5;
    localparam int unsigned ESC_SEL_MIN   = 6;
    localparam int unsigned ESC_SEL_MAX   = 7;
    localparam int unsigned ESC_RESET_MIN = 8;

    // Online activation code, received LSB first as 1,1,0,1
    localparam int unsigned OAC_BITS = 4;
    localparam logic [OAC_BITS-1:0] OAC_VALUE = 4'b1011;

    // Depth of the probe input synchronizers
    localparam int unsigned SYNC_STAGES = 2;

    // ====================
    // Types
    // ====================

    // Bridge operating state
    typedef enum logic [1:0] {
        st_offline    = 2'd0,
        st_online_act = 2'd1,
        st_oscan1     = 2'd2
    } bridge_state_t;

    // Class of the toggles seen in one TCKC high phase
    typedef enum logic [1:0] {
        esc_none     = 2'd0,
        esc_deselect = 2'd1,
        esc_select   = 2'd2,
        esc_reset    = 2'd3
    } esc_kind_t;

    // Bit slot inside a three-bit OScan1 packet
    typedef enum logic [1:0] {
        pos_ntdi = 2'd0,
        pos_tms  = 2'd1,
        pos_tdo  = 2'd2
    } pkt_pos_t;

endpackage

/* source/oscan1_jtag_driver.sv */
/* OScan1 to JTAG driver
   Builds TCK, TMS and TDI from packet bits and returns TDO on TMSC */

`timescale 1ns/100ps

module oscan1_jtag_driver (
    input  logic                     clk_i,
    input  logic                     ntrst_i,
    input  logic                     tckc_rise_i,
    input  logic                     tckc_fall_i,
    input  logic                     tdo_i,
    input  logic                     tmsc_bit_i,
    input  cjtag_pkg::bridge_state_t state_i,
    input  cjtag_pkg::pkt_pos_t      pkt_pos_i,
    output logic                     tck_o,
    output logic                     tms_o,
    output logic                     tdi_o,
    output logic                     tmsc_o,
    output logic                     tmsc_oen_o
);

    // Bridge is in packet mode
    logic in_oscan1;
    // Third packet slot belongs to the TAP
    logic in_tdo_slot;
    // TDO captured while TCK is high
    logic tdo_q;

    assign in_oscan1   = state_i == cjtag_pkg::st_oscan1;
    assign in_tdo_slot = in_oscan1 && pkt_pos_i == cjtag_pkg::pos_tdo;

    // ====================
    // JTAG outputs
    // ====================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            tck_o      <= 1'b0;
            tms_o      <= 1'b1;
            tdi_o      <= 1'b0;
            tmsc_oen_o <= 1'b1;
            tdo_q      <= 1'b0;
        end else begin
            // TAP has updated TDO once TCK is high
            if (tck_o && in_tdo_slot) begin
                tdo_q <= tdo_i;
            end

            if (!in_oscan1) begin
                // Idle levels, probe owns TMSC
                tck_o      <= 1'b0;
                tms_o      <= 1'b1;
                tdi_o      <= 1'b0;
                tmsc_oen_o <= 1'b1;
            end else begin
                if (tckc_rise_i) begin
                    case (pkt_pos_i)
                        cjtag_pkg::pos_ntdi: begin
                            // New packet, give TMSC back to the probe
                            tck_o      <= 1'b0;
                            tmsc_oen_o <= 1'b1;
                        end
                        cjtag_pkg::pos_tms: begin
                            // First bit arrives inverted
                            tdi_o      <= ~tmsc_bit_i;
                            tmsc_oen_o <= 1'b1;
                        end
                        cjtag_pkg::pos_tdo: begin
                            // TMS set and TCK raised together, TDI already stable
                            tms_o      <= tmsc_bit_i;
                            tck_o      <= 1'b1;
                            tmsc_oen_o <= 1'b0;
                        end
                        default: tmsc_oen_o <= 1'b1;
                    endcase
                end
                // End of the single TCK pulse per packet
                if (tckc_fall_i && pkt_pos_i == cjtag_pkg::pos_tdo) begin
                    tck_o <= 1'b0;
                end
            end
        end
    end

    // Returned TDO only in the third slot
    assign tmsc_o = in_tdo_slot ? tdo_q : 1'b0;

endmodule

/* src.f */
source/cjtag_pkg.sv
source/cjtag_input_sync.sv
source/cjtag_escape_detector.sv
source/cjtag_ctrl_fsm.sv
source/oscan1_jtag_driver.sv
source/cjtag_bridge.sv
sim/tb_cjtag_bridge.sv
